// File: source/tetrisPkg.sv
package tetrisPkg;

    localparam int boardRows = 22;                 // Rows 20 and 21 are spare
    localparam int visibleRows = 20;
    localparam int boardCols = 10;

    localparam logic [15:0] dropDefault = 16'd8;   // Gravity period after reset

    localparam logic [7:0] regCtrl = 8'h00;
    localparam logic [7:0] regDrop = 8'h01;
    localparam logic [7:0] regStatus = 8'h02;
    localparam logic [7:0] regLines = 8'h03;
    localparam logic [7:0] regClear = 8'h04;
    localparam logic [7:0] regRowBase = 8'h20;

    typedef logic [boardCols-1:0] rowT;            // Bit n is column n
    typedef rowT [boardRows-1:0] boardT;           // Row 0 is the top

    typedef enum logic [2:0] {
        line, square, lShape, revL, sShape, zShape, tShape
    } pieceKindT;

    typedef struct packed {
        pieceKindT kind;
        logic [3:0] column;                        // Leftmost column of the piece
    } pieceReqT;

    typedef struct packed {
        logic [3:0][3:0] cells;                    // cells[row][col] inside the 4x4 block
        logic [2:0] width;
        logic [2:0] height;
    } shapeT;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [7:0] adr;
        logic [15:0] dat;
    } wbReqT;

    typedef struct packed {
        logic ack;
        logic [15:0] dat;
    } wbRspT;

    // Block rows are given as {row3, row2, row1, row0}
    function automatic shapeT shapeMask(input pieceKindT kind);
        shapeT s;
        s = '0;
        case (kind)
            line:    s = '{cells: {4'b0001, 4'b0001, 4'b0001, 4'b0001}, width: 3'd1, height: 3'd4};
            square:  s = '{cells: {4'b0000, 4'b0000, 4'b0011, 4'b0011}, width: 3'd2, height: 3'd2};
            lShape:  s = '{cells: {4'b0000, 4'b0011, 4'b0001, 4'b0001}, width: 3'd2, height: 3'd3};
            revL:    s = '{cells: {4'b0000, 4'b0011, 4'b0010, 4'b0010}, width: 3'd2, height: 3'd3};
            sShape:  s = '{cells: {4'b0000, 4'b0000, 4'b0011, 4'b0110}, width: 3'd3, height: 3'd2};
            zShape:  s = '{cells: {4'b0000, 4'b0000, 4'b0110, 4'b0011}, width: 3'd3, height: 3'd2};
            tShape:  s = '{cells: {4'b0000, 4'b0000, 4'b0111, 4'b0010}, width: 3'd3, height: 3'd2};
            default: s = '0;                       // Unused encoding, no cells
        endcase
        return s;
    endfunction

endpackage

// File: source/lineClear.sv
`timescale 1ns/10ps

module lineClear (
    input tetrisPkg::boardT boardIn,
    output tetrisPkg::boardT boardOut,
    output logic [2:0] cleared
);

    int dst;                                       // Next free row, filled from the bottom

    // Walk from the floor upward and copy every row that is not full
    always_comb begin
        boardOut = '0;
        cleared = 3'd0;
        dst = tetrisPkg::boardRows - 1;
        for (int src = tetrisPkg::boardRows - 1; src >= 0; src--) begin
            if (&boardIn[src]) begin
                cleared = cleared + 3'd1;          // Full row disappears
            end else begin
                boardOut[dst] = boardIn[src];
                dst = dst - 1;
            end
        end
    end

endmodule

// File: source/pieceDrop.sv
`timescale 1ns/10ps

module pieceDrop (
    input logic clk,
    input logic rst,
    input logic spawn,
    input logic tick,
    input tetrisPkg::pieceKindT kind,
    input logic [3:0] column,
    input tetrisPkg::boardT settled,
    output tetrisPkg::boardT pieceMask,
    output logic landed,
    output logic spawnOverlap
);

    logic [4:0] pieceRow;                          // Top row of the 4x4 block
    logic [4:0] nextRow;
    logic [5:0] pieceBottom;                       // One past the lowest occupied row
    tetrisPkg::shapeT shape;
    tetrisPkg::boardT nextMask;
    tetrisPkg::boardT spawnMask;
    logic hitsFloor;
    logic hitsStack;

    // Draws the shape with its block corner at (row, col), cells past the edges drop out
    function automatic tetrisPkg::boardT renderMask(
        input tetrisPkg::shapeT s,
        input logic [3:0] col,
        input logic [4:0] row
    );
        tetrisPkg::boardT mask;
        int absRow;
        int absCol;
        mask = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                absRow = int'(row) + r;
                absCol = int'(col) + c;
                if (s.cells[r][c] && absRow < tetrisPkg::boardRows
                        && absCol < tetrisPkg::boardCols) begin
                    mask[absRow][absCol] = 1'b1;
                end
            end
        end
        return mask;
    endfunction

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pieceRow <= 5'd0;
        end else if (spawn) begin
            pieceRow <= 5'd0;                      // New piece enters at the top
        end else if (tick && !landed) begin
            pieceRow <= nextRow;                   // Gravity step
        end
    end

    assign shape = tetrisPkg::shapeMask(kind);
    assign nextRow = pieceRow + 5'd1;
    assign pieceBottom = {1'b0, pieceRow} + {3'b000, shape.height};

    assign pieceMask = renderMask(shape, column, pieceRow);
    assign nextMask = renderMask(shape, column, nextRow);
    assign spawnMask = renderMask(shape, column, 5'd0);

    // Moving down would leave the visible field or run into the stack
    assign hitsFloor = pieceBottom >= 6'(tetrisPkg::visibleRows);
    assign hitsStack = |(nextMask & settled);
    assign landed = hitsFloor || hitsStack;

    assign spawnOverlap = |(spawnMask & settled);

endmodule

// File: source/boardStore.sv
`timescale 1ns/10ps

module boardStore (
    input logic clk,
    input logic rst,
    input logic lockPulse,
    input logic clearPulse,
    input tetrisPkg::boardT pieceMask,
    output tetrisPkg::boardT settled,
    output logic [15:0] lineCount
);

    tetrisPkg::boardT mergedBoard;
    tetrisPkg::boardT compactBoard;
    logic [2:0] cleared;

    assign mergedBoard = settled | pieceMask;      // Landed piece joins the stack

    lineClear uLineClear (
        .boardIn(mergedBoard),
        .boardOut(compactBoard),
        .cleared(cleared)
    );

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            settled <= '0;
            lineCount <= 16'd0;
        end else if (clearPulse) begin
            settled <= '0;                         // Host wipes the field
            lineCount <= 16'd0;
        end else if (lockPulse) begin
            settled <= compactBoard;
            lineCount <= lineCount + {13'd0, cleared};
        end
    end

endmodule

// File: source/gameCtrl.sv
`timescale 1ns/10ps

module gameCtrl (
    input logic clk,
    input logic rst,
    input logic startPulse,
    input logic clearPulse,
    input tetrisPkg::pieceReqT startReq,
    input logic [15:0] dropPeriod,
    input logic landed,
    input logic spawnOverlap,
    output logic spawn,
    output logic tick,
    output logic lockPulse,
    output tetrisPkg::pieceKindT kind,
    output logic [3:0] column,
    output logic busy,
    output logic gameOver,
    output logic badReq
);

    typedef enum logic [1:0] {idle, falling, locking, over} stateT;

    stateT state;
    logic [15:0] tickCnt;                          // Cycles left until the next gravity step
    logic [15:0] period;
    tetrisPkg::shapeT reqShape;                    // Shape of the requested kind
    logic [4:0] reach;                             // Column just right of the requested piece
    logic fits;

    assign period = (dropPeriod == 16'd0) ? 16'd1 : dropPeriod;
    assign reqShape = tetrisPkg::shapeMask(startReq.kind);
    assign reach = {1'b0, startReq.column} + {2'b00, reqShape.width};
    assign fits = reach <= 5'(tetrisPkg::boardCols);

    assign tick = (state == falling) && !spawn && (tickCnt == 16'd0);
    assign lockPulse = state == locking;
    assign busy = (state == falling) || (state == locking);
    assign gameOver = state == over;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= idle;
            spawn <= 1'b0;
            badReq <= 1'b0;
            kind <= tetrisPkg::line;
            column <= 4'd0;
            tickCnt <= 16'd0;
        end else begin
            spawn <= 1'b0;
            if (clearPulse) begin
                state <= idle;                     // Aborts a falling piece too
                badReq <= 1'b0;
            end else begin
                case (state)
                    idle: begin
                        if (startPulse && fits) begin
                            state <= falling;
                            spawn <= 1'b1;
                            kind <= startReq.kind;
                            column <= startReq.column;
                            badReq <= 1'b0;
                            tickCnt <= period - 16'd1;
                        end else if (startPulse) begin
                            badReq <= 1'b1;        // Piece would stick out on the right
                        end
                    end
                    falling: begin
                        tickCnt <= (tickCnt == 16'd0) ? period - 16'd1 : tickCnt - 16'd1;
                        if (spawn && spawnOverlap) begin
                            state <= over;         // No room at the top
                        end else if (tick && landed) begin
                            state <= locking;
                        end
                    end
                    locking: state <= idle;
                    default: state <= over;        // Held until the host clears
                endcase
            end
        end
    end

endmodule

// File: source/wbRegs.sv
`timescale 1ns/10ps

module wbRegs (
    input logic clk,
    input logic rst,
    input tetrisPkg::wbReqT wbReq,
    output tetrisPkg::wbRspT wbRsp,
    input tetrisPkg::boardT settled,
    input tetrisPkg::boardT pieceMask,
    input logic [15:0] lineCount,
    input logic busy,
    input logic gameOver,
    input logic badReq,
    output logic startPulse,
    output logic clearPulse,
    output tetrisPkg::pieceReqT startReq,
    output logic [15:0] dropPeriod
);

    logic reqSeen;
    logic ack;
    logic wrAck;                                   // Write completing this cycle
    logic [15:0] rdNext;
    logic [15:0] rdData;
    logic [7:0] rowIdx;
    tetrisPkg::boardT shown;

    assign reqSeen = wbReq.cyc && wbReq.stb && !ack;
    assign wrAck = ack && wbReq.we;
    assign shown = settled | (busy ? pieceMask : '0);  // Falling piece only while busy
    assign rowIdx = wbReq.adr - tetrisPkg::regRowBase;

    always_comb begin
        rdNext = 16'd0;                            // Unmapped addresses read zero
        case (wbReq.adr)
            tetrisPkg::regDrop: rdNext = dropPeriod;
            tetrisPkg::regStatus: rdNext = {13'd0, badReq, gameOver, busy};
            tetrisPkg::regLines: rdNext = lineCount;
            default: begin
                if (wbReq.adr >= tetrisPkg::regRowBase
                        && rowIdx < 8'(tetrisPkg::boardRows)) begin
                    rdNext = {{(16 - tetrisPkg::boardCols){1'b0}}, shown[rowIdx[4:0]]};
                end
            end
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
            dropPeriod <= tetrisPkg::dropDefault;
        end else begin
            ack <= reqSeen;                        // One-cycle ack after stb
            if (wrAck && wbReq.adr == tetrisPkg::regDrop) begin
                dropPeriod <= wbReq.dat;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reqSeen) begin
            rdData <= rdNext;
        end
    end

    assign wbRsp.ack = ack;
    assign wbRsp.dat = ack ? rdData : 16'd0;

    assign startPulse = wrAck && (wbReq.adr == tetrisPkg::regCtrl);
    assign clearPulse = wrAck && (wbReq.adr == tetrisPkg::regClear);
    assign startReq.kind = tetrisPkg::pieceKindT'(wbReq.dat[6:4]);
    assign startReq.column = wbReq.dat[3:0];

endmodule

// File: source/tetrisTop.sv
`timescale 1ns/10ps

module tetrisTop (
    input logic clk,
    input logic rst,
    input tetrisPkg::wbReqT wbReq,
    output tetrisPkg::wbRspT wbRsp
);

    tetrisPkg::boardT settled;
    tetrisPkg::boardT pieceMask;
    tetrisPkg::pieceReqT startReq;
    tetrisPkg::pieceKindT kind;
    logic [15:0] lineCount;
    logic [15:0] dropPeriod;
    logic [3:0] column;
    logic startPulse, clearPulse;
    logic spawn, tick, lockPulse;
    logic landed, spawnOverlap;
    logic busy, gameOver, badReq;

    wbRegs uWbRegs (
        .clk(clk), .rst(rst), .wbReq(wbReq), .wbRsp(wbRsp),
        .settled(settled), .pieceMask(pieceMask), .lineCount(lineCount),
        .busy(busy), .gameOver(gameOver), .badReq(badReq),
        .startPulse(startPulse), .clearPulse(clearPulse),
        .startReq(startReq), .dropPeriod(dropPeriod)
    );

    gameCtrl uGameCtrl (
        .clk(clk), .rst(rst), .startPulse(startPulse), .clearPulse(clearPulse),
        .startReq(startReq), .dropPeriod(dropPeriod),
        .landed(landed), .spawnOverlap(spawnOverlap),
        .spawn(spawn), .tick(tick), .lockPulse(lockPulse),
        .kind(kind), .column(column),
        .busy(busy), .gameOver(gameOver), .badReq(badReq)
    );

    pieceDrop uPieceDrop (
        .clk(clk), .rst(rst), .spawn(spawn), .tick(tick),
        .kind(kind), .column(column), .settled(settled),
        .pieceMask(pieceMask), .landed(landed), .spawnOverlap(spawnOverlap)
    );

    boardStore uBoardStore (
        .clk(clk), .rst(rst), .lockPulse(lockPulse), .clearPulse(clearPulse),
        .pieceMask(pieceMask), .settled(settled), .lineCount(lineCount)
    );

endmodule

// File: tests/tetrisTb.sv
`timescale 1ns/10ps

module tetrisTb;

    logic clk;
    logic rst;
    tetrisPkg::wbReqT wbReq;
    tetrisPkg::wbRspT wbRsp;

    tetrisPkg::boardT model;                       // Expected settled board
    logic [15:0] modelLines;
    logic [31:0] rngState;
    int checks;
    int errors;

    tetrisTop dut (.clk(clk), .rst(rst), .wbReq(wbReq), .wbRsp(wbRsp));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Cells as {row3, row2, row1, row0} with bit 0 of a row as the left column
    function automatic logic [15:0] shapeBits(input int kind);
        case (kind)
            0: return 16'h1111;
            1: return 16'h0033;
            2: return 16'h0311;
            3: return 16'h0322;
            4: return 16'h0036;
            5: return 16'h0063;
            default: return 16'h0072;
        endcase
    endfunction

    function automatic int shapeWidth(input int kind);
        logic [15:0] s;
        int w;
        s = shapeBits(kind);
        w = 0;
        for (int i = 0; i < 16; i++) begin
            if (s[i] && (i % 4) + 1 > w) begin
                w = (i % 4) + 1;
            end
        end
        return w;
    endfunction

    function automatic tetrisPkg::boardT place(input int kind, input int col, input int row);
        tetrisPkg::boardT mask;
        logic [15:0] s;
        mask = '0;
        s = shapeBits(kind);
        for (int i = 0; i < 16; i++) begin
            if (s[i] && row + i / 4 < tetrisPkg::boardRows
                    && col + i % 4 < tetrisPkg::boardCols) begin
                mask[row + i / 4][col + i % 4] = 1'b1;
            end
        end
        return mask;
    endfunction

    function automatic bit spawnHits(input int kind, input int col);
        return |(place(kind, col, 0) & model);
    endfunction

    // Rests the piece, merges it and removes full rows; returns 1 on game over
    function automatic bit dropPiece(input int kind, input int col);
        tetrisPkg::boardT next;
        tetrisPkg::boardT merged;
        int row;
        int dst;
        if (spawnHits(kind, col)) begin
            return 1'b1;
        end
        row = 0;
        next = place(kind, col, 1);
        while (!(|(next & model))
                && next[tetrisPkg::boardRows-1:tetrisPkg::visibleRows] == '0) begin
            row++;
            next = place(kind, col, row + 1);
        end
        merged = model | place(kind, col, row);
        model = '0;
        dst = tetrisPkg::boardRows - 1;
        for (int src = tetrisPkg::boardRows - 1; src >= 0; src--) begin
            if (&merged[src]) begin
                modelLines++;                      // Full row vanishes
            end else begin
                model[dst] = merged[src];
                dst--;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic timeoutAbort(input string what);
        errors++;
        $display("Timed out waiting for %s", what);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic wbAccess(input logic we, input logic [7:0] adr, input logic [15:0] dat,
                            output logic [15:0] rd);
        int waited;
        waited = 0;
        @(posedge clk);
        wbReq <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge clk);
        while (!wbRsp.ack) begin
            waited++;
            if (waited > 20) begin
                timeoutAbort("a bus ack");
            end
            @(negedge clk);
        end
        checks++;
        if (waited != 1) begin
            errors++;
            $display("FAILED at %0t: ack came %0d cycles after the request, expected 1",
                     $time, waited);
        end
        rd = wbRsp.dat;                            // Stable at mid cycle
        @(posedge clk);
        wbReq <= '0;
    endtask

    task automatic wbWrite(input logic [7:0] adr, input logic [15:0] dat);
        logic [15:0] unused;
        wbAccess(1'b1, adr, dat, unused);
    endtask

    task automatic wbRead(input logic [7:0] adr, output logic [15:0] rd);
        wbAccess(1'b0, adr, 16'd0, rd);
    endtask

    task automatic waitIdle();
        logic [15:0] st;
        int polls;
        polls = 0;
        wbRead(tetrisPkg::regStatus, st);
        while (st[0]) begin
            polls++;
            if (polls > 200) begin
                timeoutAbort("busy to drop");
            end
            wbRead(tetrisPkg::regStatus, st);
        end
    endtask

    task automatic checkRow(input tetrisPkg::rowT got, input tetrisPkg::rowT exp,
                            input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkCount(input logic [15:0] got, input logic [15:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Status bits are {badReq, gameOver, busy}
    task automatic checkStatus(input logic [2:0] exp);
        logic [15:0] d;
        wbRead(tetrisPkg::regStatus, d);
        checks++;
        if (d[2:0] !== exp) begin
            errors++;
            $display("FAILED at %0t: status is %b, expected %b", $time, d[2:0], exp);
        end
    endtask

    task automatic checkBoard();
        logic [15:0] d;
        for (int r = 0; r < tetrisPkg::boardRows; r++) begin
            wbRead(8'(tetrisPkg::regRowBase + r), d);
            checkRow(d[tetrisPkg::boardCols-1:0], model[r], $sformatf("row %0d", r));
        end
    endtask

    task automatic checkLines();
        logic [15:0] d;
        wbRead(tetrisPkg::regLines, d);
        checkCount(d, modelLines, "line count");
    endtask

    task automatic startPiece(input int kind, input int col);
        wbWrite(tetrisPkg::regCtrl, 16'((kind << 4) | col));
    endtask

    task automatic clearBoard();
        wbWrite(tetrisPkg::regClear, 16'd0);
        model = '0;
        modelLines = 16'd0;
    endtask

    task automatic testReset();
        logic [15:0] d;
        checkStatus(3'b000);
        checkLines();
        checkBoard();
        wbRead(tetrisPkg::regDrop, d);
        checkCount(d, 16'd8, "drop period");
        wbWrite(tetrisPkg::regDrop, 16'd2);        // Short gravity period
        wbRead(tetrisPkg::regDrop, d);
        checkCount(d, 16'd2, "written drop period");
    endtask

    task automatic testShapes();
        for (int k = 0; k < 7; k++) begin
            clearBoard();
            void'(dropPiece(k, k));
            startPiece(k, k);
            waitIdle();
            checkBoard();
        end
    endtask

    task automatic testStacking();
        int kind;
        int col;
        clearBoard();
        for (int i = 0; i < 20; i++) begin
            rngState = xorshift(rngState);
            kind = int'(rngState % 32'd7);
            rngState = xorshift(rngState);
            col = int'(rngState % 32'(11 - shapeWidth(kind)));
            if (spawnHits(kind, col)) begin
                clearBoard();                      // Keep the stack alive
            end
            void'(dropPiece(kind, col));
            startPiece(kind, col);
            waitIdle();
            checkBoard();
            checkLines();
        end
    endtask

    task automatic testLineClear();
        logic [15:0] d;
        clearBoard();
        for (int c = 0; c < 10; c += 2) begin
            void'(dropPiece(1, c));
            startPiece(1, c);
            waitIdle();
        end
        wbRead(tetrisPkg::regLines, d);
        checkCount(d, 16'd2, "cleared lines");
        checkBoard();
    endtask

    task automatic testRejects();
        clearBoard();
        startPiece(0, 10);                         // Line sticks out on the right
        checkStatus(3'b100);
        checkBoard();
        void'(dropPiece(1, 0));
        startPiece(1, 0);
        startPiece(0, 5);                          // Arrives while the square falls
        waitIdle();
        checkBoard();
        checkStatus(3'b000);
    endtask

    task automatic testGameOver();
        int n;
        clearBoard();
        n = 0;
        while (!spawnHits(0, 0) && n < 20) begin
            void'(dropPiece(0, 0));
            startPiece(0, 0);
            waitIdle();
            n++;
        end
        startPiece(0, 0);
        waitIdle();
        checkStatus(3'b010);
        checkBoard();
        startPiece(1, 4);
        waitIdle();
        checkStatus(3'b010);
        checkBoard();
        clearBoard();
        checkStatus(3'b000);
        checkBoard();
        checkLines();
    endtask

    initial begin
        rst <= 1'b1;
        wbReq <= '0;
        model = '0;
        modelLines = 16'd0;
        rngState = 32'd79;
        checks = 0;
        errors = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        testReset();
        testShapes();
        testStacking();
        testLineClear();
        testRejects();
        testGameOver();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: tetrisTop.f
source/tetrisPkg.sv
source/lineClear.sv
source/pieceDrop.sv
source/boardStore.sv
source/gameCtrl.sv
source/wbRegs.sv
source/tetrisTop.sv
tests/tetrisTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tetrisTb
FILELIST ?= tetrisTop.f
BUILD ?= obj_dir
LOG ?= sim.log
PASS ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
